// File: hw/isa_pkg.sv
package isa_pkg;

    //////////////////////////////
    // Datapath widths
    //////////////////////////////

    // Operand and result width
    localparam int DATA_WIDTH     = 32;
    // Register number width, 32 registers
    localparam int REG_ADDR_WIDTH = 5;

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [2:0]                alu_op_t;

    //////////////////////////////
    // ALU operation codes
    //////////////////////////////

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    // Signed compare, result is 1 or 0
    localparam alu_op_t ALU_SLT = 3'd5;

endpackage

// File: hw/pipe_pkg.sv
package pipe_pkg;

    //////////////////////////////
    // Data memory
    //////////////////////////////

    // Word address width, 64 words
    localparam int DMEM_ADDR_WIDTH = 6;

    typedef logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_t;

    //////////////////////////////
    // Pipeline timing
    //////////////////////////////

    // Edges from issue to retire, issue edge included
    // Decode reg, execute reg, memory reg
    localparam int PIPE_LATENCY = 3;

endpackage

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter int DATA_WIDTH     = isa_pkg::DATA_WIDTH,
    parameter int REG_ADDR_WIDTH = isa_pkg::REG_ADDR_WIDTH
)(
    input  logic                      clk,
    // Read ports
    input  logic [REG_ADDR_WIDTH-1:0] rs_addr,
    input  logic [REG_ADDR_WIDTH-1:0] rt_addr,
    output logic [DATA_WIDTH-1:0]     rs_data,
    output logic [DATA_WIDTH-1:0]     rt_data,
    // Write port, from write-back
    input  logic                      we,
    input  logic [REG_ADDR_WIDTH-1:0] waddr,
    input  logic [DATA_WIDTH-1:0]     wdata
);

    // Register 0 is an ordinary register
    logic [DATA_WIDTH-1:0] regs [0:(1<<REG_ADDR_WIDTH)-1];

    //////////////////////////////
    // Write on rising edge
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (we)
            regs[waddr] <= wdata;
    end

    //////////////////////////////
    // Combinational reads
    //////////////////////////////

    // Old value on a same-cycle write
    // Write-back bypass covers that case
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

// File: hw/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit #(
    parameter int DATA_WIDTH     = isa_pkg::DATA_WIDTH,
    parameter int REG_ADDR_WIDTH = isa_pkg::REG_ADDR_WIDTH
)(
    // Operands from the register file
    input  logic                      rs_en,
    input  logic [REG_ADDR_WIDTH-1:0] rs_addr,
    input  logic [DATA_WIDTH-1:0]     rs_data,
    input  logic                      rt_en,
    input  logic [REG_ADDR_WIDTH-1:0] rt_addr,
    input  logic [DATA_WIDTH-1:0]     rt_data,
    // Execute stage, combinational ALU result
    input  logic                      exec_wb_reg,
    input  logic                      exec_uses_alu,
    input  logic [REG_ADDR_WIDTH-1:0] exec_write_addr,
    input  logic [DATA_WIDTH-1:0]     exec_write,
    // Memory stage, ALU result or RAM data
    input  logic                      mem_wb_reg,
    input  logic [REG_ADDR_WIDTH-1:0] mem_write_addr,
    input  logic [DATA_WIDTH-1:0]     mem_write,
    // Write-back stage, same cycle as the RF write
    input  logic                      wb_wb_reg,
    input  logic [REG_ADDR_WIDTH-1:0] wb_write_addr,
    input  logic [DATA_WIDTH-1:0]     wb_write,
    // Corrected operands
    output logic [DATA_WIDTH-1:0]     rs_value,
    output logic [DATA_WIDTH-1:0]     rt_value
);

    import isa_pkg::*;

    // Youngest matching producer wins
    // Load data not known yet in execute
    function automatic data_t bypass(
        input logic      en,
        input reg_addr_t addr,
        input data_t     rf_value
    );
        data_t value;
        value = rf_value;
        if (en)
        begin
            if (exec_wb_reg && exec_uses_alu && (addr == exec_write_addr))
                value = exec_write;
            else if (mem_wb_reg && (addr == mem_write_addr))
                value = mem_write;
            else if (wb_wb_reg && (addr == wb_write_addr))
                value = wb_write;
        end
        return value;
    endfunction

    // Same rule for both operands
    always_comb
    begin
        rs_value = bypass(rs_en, rs_addr, rs_data);
        rt_value = bypass(rt_en, rt_addr, rt_data);
    end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
    parameter int DATA_WIDTH     = isa_pkg::DATA_WIDTH,
    parameter int REG_ADDR_WIDTH = isa_pkg::REG_ADDR_WIDTH
)(
    input  logic                      clk,
    input  logic                      arst_n,
    // Decoded instruction from the issuer
    input  logic                      issue,
    input  logic                      rs_en,
    input  logic [REG_ADDR_WIDTH-1:0] rs_addr,
    input  logic                      rt_en,
    input  logic [REG_ADDR_WIDTH-1:0] rt_addr,
    input  logic [REG_ADDR_WIDTH-1:0] rd_addr,
    input  isa_pkg::alu_op_t          alu_op,
    input  logic [DATA_WIDTH-1:0]     imm,
    input  logic                      use_imm,
    input  logic                      is_load,
    input  logic                      is_store,
    // Execute bypass
    input  logic                      exec_wb_reg,
    input  logic                      exec_uses_alu,
    input  logic [REG_ADDR_WIDTH-1:0] exec_write_addr,
    input  logic [DATA_WIDTH-1:0]     exec_write,
    // Memory bypass
    input  logic                      mem_wb_reg,
    input  logic [REG_ADDR_WIDTH-1:0] mem_write_addr,
    input  logic [DATA_WIDTH-1:0]     mem_write,
    // RF write, doubles as write-back bypass
    input  logic                      rf_we,
    input  logic [REG_ADDR_WIDTH-1:0] rf_waddr,
    input  logic [DATA_WIDTH-1:0]     rf_wdata,
    // Decode-to-execute register
    output logic                      ex_valid,
    output logic [REG_ADDR_WIDTH-1:0] ex_rd,
    output logic                      ex_wb_reg,
    output logic                      ex_is_load,
    output logic                      ex_is_store,
    output isa_pkg::alu_op_t          ex_alu_op,
    output logic                      ex_use_imm,
    output logic [DATA_WIDTH-1:0]     ex_imm,
    output logic [DATA_WIDTH-1:0]     ex_rs_value,
    output logic [DATA_WIDTH-1:0]     ex_rt_value
);

    logic [DATA_WIDTH-1:0] rs_data;
    logic [DATA_WIDTH-1:0] rt_data;
    logic [DATA_WIDTH-1:0] rs_value;
    logic [DATA_WIDTH-1:0] rt_value;

    //////////////////////////////
    // Operand fetch
    //////////////////////////////

    reg_file #(
        .DATA_WIDTH     (DATA_WIDTH),
        .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
    ) i_reg_file (
        .clk     (clk),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    forwarding_unit #(
        .DATA_WIDTH     (DATA_WIDTH),
        .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
    ) i_forwarding_unit (
        .rs_en           (rs_en),
        .rs_addr         (rs_addr),
        .rs_data         (rs_data),
        .rt_en           (rt_en),
        .rt_addr         (rt_addr),
        .rt_data         (rt_data),
        .exec_wb_reg     (exec_wb_reg),
        .exec_uses_alu   (exec_uses_alu),
        .exec_write_addr (exec_write_addr),
        .exec_write      (exec_write),
        .mem_wb_reg      (mem_wb_reg),
        .mem_write_addr  (mem_write_addr),
        .mem_write       (mem_write),
        .wb_wb_reg       (rf_we),
        .wb_write_addr   (rf_waddr),
        .wb_write        (rf_wdata),
        .rs_value        (rs_value),
        .rt_value        (rt_value)
    );

    //////////////////////////////
    // Decode-to-execute register
    //////////////////////////////

    // Control flags, cleared on reset
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ex_valid    <= 1'b0;
            ex_wb_reg   <= 1'b0;
            ex_is_load  <= 1'b0;
            ex_is_store <= 1'b0;
        end
        else
        begin
            ex_valid    <= issue;
            // Stores never write a register
            ex_wb_reg   <= issue && !is_store;
            ex_is_load  <= issue && is_load;
            ex_is_store <= issue && is_store;
        end
    end

    // Payload
    always_ff @(posedge clk)
    begin
        ex_rd       <= rd_addr;
        ex_alu_op   <= alu_op;
        ex_use_imm  <= use_imm;
        ex_imm      <= imm;
        ex_rs_value <= rs_value;
        ex_rt_value <= rt_value;
    end

endmodule

// File: hw/exec_stage.sv
`timescale 1ns/1ps

module exec_stage #(
    parameter int DATA_WIDTH     = isa_pkg::DATA_WIDTH,
    parameter int REG_ADDR_WIDTH = isa_pkg::REG_ADDR_WIDTH
)(
    input  logic                      clk,
    input  logic                      arst_n,
    // From decode-to-execute register
    input  logic                      ex_valid,
    input  logic [REG_ADDR_WIDTH-1:0] ex_rd,
    input  logic                      ex_wb_reg,
    input  logic                      ex_is_load,
    input  logic                      ex_is_store,
    input  isa_pkg::alu_op_t          ex_alu_op,
    input  logic                      ex_use_imm,
    input  logic [DATA_WIDTH-1:0]     ex_imm,
    input  logic [DATA_WIDTH-1:0]     ex_rs_value,
    input  logic [DATA_WIDTH-1:0]     ex_rt_value,
    // Execute bypass back to decode
    output logic [DATA_WIDTH-1:0]     alu_result,
    output logic                      fwd_wb_reg,
    output logic                      fwd_uses_alu,
    output logic [REG_ADDR_WIDTH-1:0] fwd_rd,
    // Execute-to-memory register
    output logic                      mem_valid,
    output logic [REG_ADDR_WIDTH-1:0] mem_rd,
    output logic                      mem_wb_reg,
    output logic                      mem_is_load,
    output logic                      mem_is_store,
    output logic [DATA_WIDTH-1:0]     mem_alu_result,
    output logic [DATA_WIDTH-1:0]     mem_store_data
);

    import isa_pkg::*;

    data_t op_b;

    //////////////////////////////
    // ALU
    //////////////////////////////

    assign op_b = ex_use_imm ? ex_imm : ex_rt_value;

    always_comb
    begin
        case (ex_alu_op)
            ALU_ADD: alu_result = ex_rs_value + op_b;
            ALU_SUB: alu_result = ex_rs_value - op_b;
            ALU_AND: alu_result = ex_rs_value & op_b;
            ALU_OR:  alu_result = ex_rs_value | op_b;
            ALU_XOR: alu_result = ex_rs_value ^ op_b;
            // Zero-extended compare flag
            ALU_SLT: alu_result = {{(DATA_WIDTH-1){1'b0}},
                                   $signed(ex_rs_value) < $signed(op_b)};
            default: alu_result = '0;
        endcase
    end

    // Load result unknown until memory
    assign fwd_wb_reg   = ex_wb_reg;
    assign fwd_uses_alu = !ex_is_load;
    assign fwd_rd       = ex_rd;

    //////////////////////////////
    // Execute-to-memory register
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mem_valid    <= 1'b0;
            mem_wb_reg   <= 1'b0;
            mem_is_load  <= 1'b0;
            mem_is_store <= 1'b0;
        end
        else
        begin
            mem_valid    <= ex_valid;
            mem_wb_reg   <= ex_wb_reg;
            mem_is_load  <= ex_is_load;
            mem_is_store <= ex_is_store;
        end
    end

    // Store data is the forwarded rt
    always_ff @(posedge clk)
    begin
        mem_rd         <= ex_rd;
        mem_alu_result <= alu_result;
        mem_store_data <= ex_rt_value;
    end

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage #(
    parameter int DATA_WIDTH      = isa_pkg::DATA_WIDTH,
    parameter int REG_ADDR_WIDTH  = isa_pkg::REG_ADDR_WIDTH,
    parameter int DMEM_ADDR_WIDTH = pipe_pkg::DMEM_ADDR_WIDTH
)(
    input  logic                      clk,
    input  logic                      arst_n,
    // From execute-to-memory register
    input  logic                      mem_valid,
    input  logic [REG_ADDR_WIDTH-1:0] mem_rd,
    input  logic                      mem_wb_reg,
    input  logic                      mem_is_load,
    input  logic                      mem_is_store,
    input  logic [DATA_WIDTH-1:0]     mem_alu_result,
    input  logic [DATA_WIDTH-1:0]     mem_store_data,
    // Memory bypass
    output logic [DATA_WIDTH-1:0]     mem_result,
    // Memory-to-write-back register
    output logic                      wb_valid,
    output logic [REG_ADDR_WIDTH-1:0] wb_rd,
    output logic                      wb_wb_reg,
    output logic [DATA_WIDTH-1:0]     wb_result
);

    import pipe_pkg::*;

    logic [DATA_WIDTH-1:0] ram [0:(1<<DMEM_ADDR_WIDTH)-1];
    dmem_addr_t            ram_addr;

    //////////////////////////////
    // Data RAM
    //////////////////////////////

    // Word address, upper ALU bits dropped
    assign ram_addr = mem_alu_result[DMEM_ADDR_WIDTH-1:0];

    always_ff @(posedge clk)
    begin
        if (mem_is_store)
            ram[ram_addr] <= mem_store_data;
    end

    // Combinational read for loads
    assign mem_result = mem_is_load ? ram[ram_addr] : mem_alu_result;

    //////////////////////////////
    // Memory-to-write-back register
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_valid  <= 1'b0;
            wb_wb_reg <= 1'b0;
        end
        else
        begin
            wb_valid  <= mem_valid;
            wb_wb_reg <= mem_wb_reg;
        end
    end

    // A store retires with its data
    always_ff @(posedge clk)
    begin
        wb_rd     <= mem_rd;
        wb_result <= mem_is_store ? mem_store_data : mem_result;
    end

endmodule

// File: hw/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage #(
    parameter int DATA_WIDTH     = isa_pkg::DATA_WIDTH,
    parameter int REG_ADDR_WIDTH = isa_pkg::REG_ADDR_WIDTH
)(
    // From memory-to-write-back register
    input  logic                      wb_valid,
    input  logic [REG_ADDR_WIDTH-1:0] wb_rd,
    input  logic                      wb_wb_reg,
    input  logic [DATA_WIDTH-1:0]     wb_result,
    // Register-file write, also the write-back bypass
    output logic                      rf_we,
    output logic [REG_ADDR_WIDTH-1:0] rf_waddr,
    output logic [DATA_WIDTH-1:0]     rf_wdata,
    // Retire report
    output logic                      retire_valid,
    output logic [REG_ADDR_WIDTH-1:0] retire_addr,
    output logic [DATA_WIDTH-1:0]     retire_data
);

    // Only valid register writers reach the RF
    assign rf_we    = wb_valid && wb_wb_reg;
    assign rf_waddr = wb_rd;
    assign rf_wdata = wb_result;

    // Every valid instruction retires
    // For a store, address register field and store data
    assign retire_valid = wb_valid;
    assign retire_addr  = wb_rd;
    assign retire_data  = wb_result;

endmodule

// File: hw/int_pipeline.sv
`timescale 1ns/1ps

module int_pipeline #(
    parameter int DATA_WIDTH      = isa_pkg::DATA_WIDTH,
    parameter int REG_ADDR_WIDTH  = isa_pkg::REG_ADDR_WIDTH,
    parameter int DMEM_ADDR_WIDTH = pipe_pkg::DMEM_ADDR_WIDTH
)(
    input  logic                      clk,
    input  logic                      arst_n,
    // Issue inputs
    input  logic                      issue,
    input  logic                      rs_en,
    input  logic [REG_ADDR_WIDTH-1:0] rs_addr,
    input  logic                      rt_en,
    input  logic [REG_ADDR_WIDTH-1:0] rt_addr,
    input  logic [REG_ADDR_WIDTH-1:0] rd_addr,
    input  isa_pkg::alu_op_t          alu_op,
    input  logic [DATA_WIDTH-1:0]     imm,
    input  logic                      use_imm,
    input  logic                      is_load,
    input  logic                      is_store,
    // Retire outputs
    output logic                      retire_valid,
    output logic [REG_ADDR_WIDTH-1:0] retire_addr,
    output logic [DATA_WIDTH-1:0]     retire_data,
    output logic                      retire_wb
);

    // Decode to execute
    logic                      ex_valid;
    logic [REG_ADDR_WIDTH-1:0] ex_rd;
    logic                      ex_wb_reg;
    logic                      ex_is_load;
    logic                      ex_is_store;
    isa_pkg::alu_op_t          ex_alu_op;
    logic                      ex_use_imm;
    logic [DATA_WIDTH-1:0]     ex_imm;
    logic [DATA_WIDTH-1:0]     ex_rs_value;
    logic [DATA_WIDTH-1:0]     ex_rt_value;
    // Execute bypass
    logic [DATA_WIDTH-1:0]     alu_result;
    logic                      fwd_wb_reg;
    logic                      fwd_uses_alu;
    logic [REG_ADDR_WIDTH-1:0] fwd_rd;
    // Execute to memory
    logic                      mem_valid;
    logic [REG_ADDR_WIDTH-1:0] mem_rd;
    logic                      mem_wb_reg;
    logic                      mem_is_load;
    logic                      mem_is_store;
    logic [DATA_WIDTH-1:0]     mem_alu_result;
    logic [DATA_WIDTH-1:0]     mem_store_data;
    logic [DATA_WIDTH-1:0]     mem_result;
    // Memory to write-back
    logic                      wb_valid;
    logic [REG_ADDR_WIDTH-1:0] wb_rd;
    logic                      wb_wb_reg;
    logic [DATA_WIDTH-1:0]     wb_result;
    // Register-file write
    logic                      rf_we;
    logic [REG_ADDR_WIDTH-1:0] rf_waddr;
    logic [DATA_WIDTH-1:0]     rf_wdata;

    //////////////////////////////
    // Stages
    //////////////////////////////

    decode_stage #(
        .DATA_WIDTH     (DATA_WIDTH),
        .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
    ) i_decode_stage (
        .clk             (clk),
        .arst_n          (arst_n),
        .issue           (issue),
        .rs_en           (rs_en),
        .rs_addr         (rs_addr),
        .rt_en           (rt_en),
        .rt_addr         (rt_addr),
        .rd_addr         (rd_addr),
        .alu_op          (alu_op),
        .imm             (imm),
        .use_imm         (use_imm),
        .is_load         (is_load),
        .is_store        (is_store),
        .exec_wb_reg     (fwd_wb_reg),
        .exec_uses_alu   (fwd_uses_alu),
        .exec_write_addr (fwd_rd),
        .exec_write      (alu_result),
        .mem_wb_reg      (mem_wb_reg),
        .mem_write_addr  (mem_rd),
        .mem_write       (mem_result),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata),
        .ex_valid        (ex_valid),
        .ex_rd           (ex_rd),
        .ex_wb_reg       (ex_wb_reg),
        .ex_is_load      (ex_is_load),
        .ex_is_store     (ex_is_store),
        .ex_alu_op       (ex_alu_op),
        .ex_use_imm      (ex_use_imm),
        .ex_imm          (ex_imm),
        .ex_rs_value     (ex_rs_value),
        .ex_rt_value     (ex_rt_value)
    );

    exec_stage #(
        .DATA_WIDTH     (DATA_WIDTH),
        .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
    ) i_exec_stage (
        .clk            (clk),
        .arst_n         (arst_n),
        .ex_valid       (ex_valid),
        .ex_rd          (ex_rd),
        .ex_wb_reg      (ex_wb_reg),
        .ex_is_load     (ex_is_load),
        .ex_is_store    (ex_is_store),
        .ex_alu_op      (ex_alu_op),
        .ex_use_imm     (ex_use_imm),
        .ex_imm         (ex_imm),
        .ex_rs_value    (ex_rs_value),
        .ex_rt_value    (ex_rt_value),
        .alu_result     (alu_result),
        .fwd_wb_reg     (fwd_wb_reg),
        .fwd_uses_alu   (fwd_uses_alu),
        .fwd_rd         (fwd_rd),
        .mem_valid      (mem_valid),
        .mem_rd         (mem_rd),
        .mem_wb_reg     (mem_wb_reg),
        .mem_is_load    (mem_is_load),
        .mem_is_store   (mem_is_store),
        .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data)
    );

    mem_stage #(
        .DATA_WIDTH      (DATA_WIDTH),
        .REG_ADDR_WIDTH  (REG_ADDR_WIDTH),
        .DMEM_ADDR_WIDTH (DMEM_ADDR_WIDTH)
    ) i_mem_stage (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_valid      (mem_valid),
        .mem_rd         (mem_rd),
        .mem_wb_reg     (mem_wb_reg),
        .mem_is_load    (mem_is_load),
        .mem_is_store   (mem_is_store),
        .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data),
        .mem_result     (mem_result),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_wb_reg      (wb_wb_reg),
        .wb_result      (wb_result)
    );

    writeback_stage #(
        .DATA_WIDTH     (DATA_WIDTH),
        .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
    ) i_writeback_stage (
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_wb_reg    (wb_wb_reg),
        .wb_result    (wb_result),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .retire_valid (retire_valid),
        .retire_addr  (retire_addr),
        .retire_data  (retire_data)
    );

    // Retired instruction wrote a register
    assign retire_wb = rf_we;

endmodule

// File: sim/int_pipeline_tb.sv
`timescale 1ns/1ps

module int_pipeline_tb;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int NUM_REGS     = 1 << REG_ADDR_WIDTH;
    localparam int NUM_WORDS    = 1 << DMEM_ADDR_WIDTH;
    localparam int RANDOM_COUNT = 400;
    // Zero pass, value pass, one store per word
    localparam int INIT_SLOTS   = 2 * NUM_REGS + NUM_WORDS;
    localparam int MAX_CYCLES   = RESET_CYCLES + INIT_SLOTS + 20 + 2 * RANDOM_COUNT
                                  + PIPE_LATENCY + 20;

    // One expected retire
    typedef struct packed {
        int unsigned due;
        reg_addr_t   addr;
        data_t       data;
        logic        wb;
    } retire_t;

    // One register write on its way to the RF
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        data_t     data;
    } rf_write_t;

    logic        clk;
    logic        arst_n;
    logic        issue;
    logic        rs_en;
    reg_addr_t   rs_addr;
    logic        rt_en;
    reg_addr_t   rt_addr;
    reg_addr_t   rd_addr;
    alu_op_t     alu_op;
    data_t       imm;
    logic        use_imm;
    logic        is_load;
    logic        is_store;
    logic        retire_valid;
    reg_addr_t   retire_addr;
    data_t       retire_data;
    logic        retire_wb;

    int unsigned cycle;

    // Architectural state, plus what the RF itself holds
    data_t       arch [0:NUM_REGS-1];
    data_t       rf_view [0:NUM_REGS-1];
    data_t       ram_ref [0:NUM_WORDS-1];
    retire_t     expected [$];
    rf_write_t   pending [$];
    logic        last_load;
    reg_addr_t   last_load_rd;

    int_pipeline #(
        .DATA_WIDTH      (DATA_WIDTH),
        .REG_ADDR_WIDTH  (REG_ADDR_WIDTH),
        .DMEM_ADDR_WIDTH (DMEM_ADDR_WIDTH)
    ) i_int_pipeline (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue        (issue),
        .rs_en        (rs_en),
        .rs_addr      (rs_addr),
        .rt_en        (rt_en),
        .rt_addr      (rt_addr),
        .rd_addr      (rd_addr),
        .alu_op       (alu_op),
        .imm          (imm),
        .use_imm      (use_imm),
        .is_load      (is_load),
        .is_store     (is_store),
        .retire_valid (retire_valid),
        .retire_addr  (retire_addr),
        .retire_data  (retire_data),
        .retire_wb    (retire_wb)
    );

    always #2 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic data_t alu_ref(input alu_op_t op, input data_t a, input data_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return ($signed(a) < $signed(b)) ? 1 : 0;
            default: return '0;
        endcase
    endfunction

    // One clock slot, issue or bubble, driven 1 ns after the edge
    task automatic run_slot(
        input logic      iss,
        input alu_op_t   op,
        input reg_addr_t rd,
        input reg_addr_t rs,
        input logic      rs_on,
        input reg_addr_t rt,
        input logic      rt_on,
        input data_t     imm_val,
        input logic      imm_sel,
        input logic      ld,
        input logic      st
    );
        data_t     a;
        data_t     b;
        data_t     res;
        rf_write_t wr;
        @(posedge clk);
        #1;
        issue    = iss;
        alu_op   = op;
        rd_addr  = rd;
        rs_addr  = rs;
        rs_en    = rs_on;
        rt_addr  = rt;
        rt_en    = rt_on;
        imm      = imm_val;
        use_imm  = imm_sel;
        is_load  = ld;
        is_store = st;
        // Disabled operand sees the RF as it stands, no bypass
        a = rs_on ? arch[rs] : rf_view[rs];
        b = rt_on ? arch[rt] : rf_view[rt];
        res = alu_ref(op, a, imm_sel ? imm_val : b);
        wr = '{we: 1'b0, addr: rd, data: '0};
        if (iss && st)
        begin
            ram_ref[res[DMEM_ADDR_WIDTH-1:0]] = b;
            expected.push_back('{due: cycle + PIPE_LATENCY, addr: rd, data: b, wb: 1'b0});
        end
        else if (iss)
        begin
            if (ld)
                res = ram_ref[res[DMEM_ADDR_WIDTH-1:0]];
            arch[rd] = res;
            wr = '{we: 1'b1, addr: rd, data: res};
            // Retire window opens two edges after the issue edge
            expected.push_back('{due: cycle + PIPE_LATENCY, addr: rd, data: res, wb: 1'b1});
        end
        // RF catches up PIPE_LATENCY slots later
        pending.push_back(wr);
        if (pending.size() > PIPE_LATENCY)
        begin
            wr = pending.pop_front();
            if (wr.we)
                rf_view[wr.addr] = wr.data;
        end
        last_load    = iss && ld;
        last_load_rd = rd;
    endtask

    task automatic idle_slot();
        run_slot(1'b0, ALU_ADD, 0, 0, 1'b0, 0, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    // Small register set, so dependencies at every distance
    task automatic random_instr();
        int unsigned kind;
        alu_op_t     op;
        reg_addr_t   rd;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic        rs_on;
        logic        rt_on;
        logic        imm_sel;
        logic        ld;
        logic        st;
        data_t       imm_val;
        kind    = $urandom % 8;
        ld      = (kind == 0);
        st      = (kind == 1);
        op      = (ld || st) ? ALU_ADD : alu_op_t'($urandom % 6);
        rd      = $urandom % 8;
        rs      = $urandom % 8;
        rt      = $urandom % 8;
        rs_on   = ($urandom % 10) != 0;
        rt_on   = ($urandom % 10) != 0;
        imm_sel = (ld || st) ? 1'b1 : 1'($urandom % 2);
        imm_val = $urandom;
        // No load-use in the very next instruction
        if (last_load && rs == last_load_rd)
            rs_on = 1'b0;
        if (last_load && rt == last_load_rd)
            rt_on = 1'b0;
        run_slot(1'b1, op, rd, rs, rs_on, rt, rt_on, imm_val, imm_sel, ld, st);
    endtask

    //////////////////////////////
    // Retire checks
    //////////////////////////////

    // Sampled mid-cycle, outputs settled
    always @(negedge clk)
    begin
        retire_t exp_r;
        if (retire_valid === 1'b1)
        begin
            assert (expected.size() > 0)
            else stop_on_error("A retire came out with no instruction outstanding");
            exp_r = expected.pop_front();
            assert (cycle == exp_r.due)
            else stop_on_error($sformatf("Instruction retired at cycle %0d, due at cycle %0d",
                                         cycle, exp_r.due));
            assert (retire_addr === exp_r.addr)
            else stop_on_error($sformatf("Fail at time %0t: retire_addr expected %0d got %0d",
                                         $time, exp_r.addr, retire_addr));
            assert (retire_data === exp_r.data)
            else stop_on_error($sformatf("Fail at time %0t: retire_data expected %h got %h",
                                         $time, exp_r.data, retire_data));
            assert (retire_wb === exp_r.wb)
            else stop_on_error($sformatf("Fail at time %0t: retire_wb expected %b got %b",
                                         $time, exp_r.wb, retire_wb));
        end
        else
        begin
            assert (retire_valid === 1'b0)
            else stop_on_error("retire_valid is neither high nor low");
            if (expected.size() > 0)
            begin
                exp_r = expected[0];
                assert (cycle < exp_r.due)
                else stop_on_error($sformatf("Instruction due at cycle %0d never retired",
                                             exp_r.due));
            end
        end
    end

    // Cycle count and run limit
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES)
            stop_on_error($sformatf("Run did not finish within %0d cycles", MAX_CYCLES));
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial
    begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        issue        = 1'b0;
        rs_en        = 1'b0;
        rs_addr      = '0;
        rt_en        = 1'b0;
        rt_addr      = '0;
        rd_addr      = '0;
        alu_op       = ALU_ADD;
        imm          = '0;
        use_imm      = 1'b0;
        is_load      = 1'b0;
        is_store     = 1'b0;
        cycle        = 0;
        last_load    = 1'b0;
        last_load_rd = '0;
        void'($urandom(94));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // Quiet pipeline after reset
        repeat (5) idle_slot();
        // Clear every register, AND with zero
        for (int r = 0; r < NUM_REGS; r++)
            run_slot(1'b1, ALU_AND, r, r, 1'b1, 0, 1'b0, '0, 1'b1, 1'b0, 1'b0);
        for (int r = 0; r < NUM_REGS; r++)
            run_slot(1'b1, ALU_ADD, r, r, 1'b1, 0, 1'b0, $urandom, 1'b1, 1'b0, 1'b0);
        // Fill each RAM word, address r0 plus immediate
        for (int w = 0; w < NUM_WORDS; w++)
            run_slot(1'b1, ALU_ADD, $urandom % 32, 0, 1'b1, $urandom % 32, 1'b1,
                     w - arch[0], 1'b1, 1'b0, 1'b1);
        // Two writes to r10 in a row, youngest must win
        run_slot(1'b1, ALU_ADD, 10, 10, 1'b1, 0, 1'b0, 32'd5, 1'b1, 1'b0, 1'b0);
        run_slot(1'b1, ALU_ADD, 10, 10, 1'b1, 0, 1'b0, 32'd7, 1'b1, 1'b0, 1'b0);
        run_slot(1'b1, ALU_ADD, 11, 10, 1'b1, 0, 1'b0, '0, 1'b1, 1'b0, 1'b0);
        // Store to word 3, load it back
        run_slot(1'b1, ALU_ADD, 20, 0, 1'b1, 11, 1'b1, 32'd3 - arch[0], 1'b1, 1'b0, 1'b1);
        run_slot(1'b1, ALU_ADD, 12, 0, 1'b1, 0, 1'b0, 32'd3 - arch[0], 1'b1, 1'b1, 1'b0);
        run_slot(1'b1, ALU_OR, 13, 13, 1'b1, 0, 1'b0, 32'h0f0, 1'b1, 1'b0, 1'b0);
        // Load data two later, memory bypass
        run_slot(1'b1, ALU_ADD, 14, 12, 1'b1, 12, 1'b1, '0, 1'b0, 1'b0, 1'b0);
        // rs disabled, pending write to r15 not bypassed
        run_slot(1'b1, ALU_ADD, 15, 15, 1'b1, 0, 1'b0, 32'd1, 1'b1, 1'b0, 1'b0);
        run_slot(1'b1, ALU_ADD, 16, 15, 1'b0, 0, 1'b0, 32'd2, 1'b1, 1'b0, 1'b0);
        // Random mix with occasional bubbles
        for (int i = 0; i < RANDOM_COUNT; i++)
        begin
            if (($urandom % 8) == 0)
                idle_slot();
            random_instr();
        end
        // Drain
        while (expected.size() != 0)
            idle_slot();
        repeat (4) idle_slot();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: verilog.f
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/reg_file.sv
hw/forwarding_unit.sv
hw/decode_stage.sv
hw/exec_stage.sv
hw/mem_stage.sv
hw/writeback_stage.sv
hw/int_pipeline.sv
sim/int_pipeline_tb.sv
